/* hdl/dts_pkg.sv */
package dts_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // One antenna's worth of deformatters
  localparam int N_DTS = 12;

  // Command buffer geometry
  localparam int CMD_DEPTH   = 4;
  localparam int CMD_PTR_W   = $clog2(CMD_DEPTH);
  localparam int CMD_LEVEL_W = 3;

  // Write/read strobe length on the deformatter bus
  localparam int STROBE_CYCLES = 4;
  localparam int STROBE_CNT_W  = $clog2(STROBE_CYCLES);

  // Register indices, matched against wb_adr_i[5:2]
  localparam logic [3:0] REG_CONTROL = 4'd0;
  localparam logic [3:0] REG_DELAY   = 4'd1;
  localparam logic [3:0] REG_MUX_LO  = 4'd2;
  localparam logic [3:0] REG_MUX_HI  = 4'd3;
  localparam logic [3:0] REG_MODE    = 4'd4;
  localparam logic [3:0] REG_STATUS  = 4'd5;

  // Sequencer state codes
  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_STROBE = 2'd1;
  localparam logic [1:0] ST_GAP    = 2'd2;

  // Control word, raw on the bus side, split into fields on the port side
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic             spare;
      logic [N_DTS-1:0] cs;
      logic             unmute;
      logic             rd;
      logic             wr;
      logic [7:0]       addr;
      logic [7:0]       data;
    } fields;
  } dts_ctrl_word_u;

endpackage

/* hdl/dts_fifo_if.sv */
`timescale 1ns/1ps

interface dts_fifo_if import dts_pkg::*; ();

  // Producer side
  logic                   push;
  dts_ctrl_word_u         push_word;
  logic                   full;
  logic [CMD_LEVEL_W-1:0] level;

  // Consumer side, pop_word always shows the oldest entry
  logic                   pop;
  dts_ctrl_word_u         pop_word;
  logic                   empty;

  modport writer (output push, push_word, input full, level);

  modport store (
    input  push, push_word, pop,
    output full, level, pop_word, empty
  );

  modport reader (output pop, input pop_word, empty);

endinterface

/* hdl/dts_reg_slave.sv */
`timescale 1ns/1ps

module dts_reg_slave import dts_pkg::*; (
  input  logic             user_clk,
  input  logic             wb_rst_i,
  // Wishbone slave
  input  logic [31:0]      wb_adr_i,
  input  logic [3:0]       wb_sel_i,
  input  logic [31:0]      wb_dat_i,
  input  logic             wb_we_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  output logic [31:0]      wb_dat_o,
  output logic             wb_ack_o,
  output logic             wb_err_o,
  // Read-back from the port sequencer
  input  logic             status_we_i,
  input  logic [31:0]      status_word_i,
  // Delay control
  output logic [N_DTS-1:0] shift_advance_o,
  output logic [N_DTS-1:0] shift_delay_o,
  output logic             shift_rst_o,
  // Mux control
  output logic [47:0]      mux_control_o,
  output logic             is_three_bit_o,
  // Command queue
  dts_fifo_if.writer       cmd
);

  logic [3:0]     reg_idx;
  logic           req;
  logic           ctrl_wr;
  logic           ctrl_refuse;
  logic           buf_empty;
  logic [31:0]    rd_data;

  logic [31:0]    delay_reg;
  logic [47:0]    mux_reg;
  logic           mode_reg;
  logic [31:0]    status_reg;
  logic           push_q;
  dts_ctrl_word_u push_word_q;

  //////////////////////////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////////////////////////

  // Word select only, wb_sel_i is not honoured
  assign reg_idx = wb_adr_i[5:2];

  // New request, blocked while the previous one is being answered
  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;

  assign ctrl_wr     = req & wb_we_i & (reg_idx == REG_CONTROL);
  assign ctrl_refuse = ctrl_wr & cmd.full;
  assign buf_empty   = (cmd.level == '0);

  // Read mux
  always_comb begin
    case (reg_idx)
      REG_CONTROL: rd_data = status_reg;
      REG_DELAY:   rd_data = delay_reg;
      REG_MUX_LO:  rd_data = mux_reg[31:0];
      REG_MUX_HI:  rd_data = {16'd0, mux_reg[47:32]};
      REG_MODE:    rd_data = {31'd0, mode_reg};
      // Level low, empty at bit 8, full at bit 9
      REG_STATUS:  rd_data = {22'd0, cmd.full, buf_empty, 5'd0, cmd.level};
      default:     rd_data = 32'd0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Registers and response
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      wb_err_o   <= 1'b0;
      wb_dat_o   <= 32'd0;
      push_q     <= 1'b0;
      delay_reg  <= 32'd0;
      mux_reg    <= 48'd0;
      mode_reg   <= 1'b0;
      status_reg <= 32'd0;
    end else begin
      // Full buffer turns the ack into an error
      wb_ack_o <= req & ~ctrl_refuse;
      wb_err_o <= ctrl_refuse;
      // Push lines up with the ack
      push_q   <= ctrl_wr & ~cmd.full;

      // Latest read result from the deformatters
      if (status_we_i) begin
        status_reg <= status_word_i;
      end

      if (req && wb_we_i) begin
        case (reg_idx)
          REG_DELAY:  delay_reg      <= wb_dat_i;
          REG_MUX_LO: mux_reg[31:0]  <= wb_dat_i;
          REG_MUX_HI: mux_reg[47:32] <= wb_dat_i[15:0];
          REG_MODE:   mode_reg       <= wb_dat_i[0];
          default: ;
        endcase
      end

      if (req && !wb_we_i) begin
        wb_dat_o <= rd_data;
      end
    end
  end

  // Command payload
  always_ff @(posedge user_clk) begin
    if (ctrl_wr) begin
      push_word_q.raw <= wb_dat_i;
    end
  end

  assign cmd.push      = push_q;
  assign cmd.push_word = push_word_q;

  // Level outputs straight from the registers
  assign shift_advance_o = delay_reg[11:0];
  assign shift_delay_o   = delay_reg[23:12];
  assign shift_rst_o     = delay_reg[31];
  assign mux_control_o   = mux_reg;
  assign is_three_bit_o  = mode_reg;

endmodule

/* hdl/dts_cmd_fifo.sv */
`timescale 1ns/1ps

module dts_cmd_fifo import dts_pkg::*; (
  input  logic      user_clk,
  input  logic      wb_rst_i,
  dts_fifo_if.store cmd
);

  dts_ctrl_word_u         mem [CMD_DEPTH];
  logic [CMD_PTR_W-1:0]   wr_ptr;
  logic [CMD_PTR_W-1:0]   rd_ptr;
  logic [CMD_LEVEL_W-1:0] level_q;
  logic                   do_push;
  logic                   do_pop;

  // Guard against a misbehaving producer or consumer
  assign do_push = cmd.push & ~cmd.full;
  assign do_pop  = cmd.pop & ~cmd.empty;

  // Storage
  always_ff @(posedge user_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= cmd.push_word;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level_q <= '0;
    end else begin
      // Depth is a power of two, pointers wrap on their own
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  // Oldest word on view
  assign cmd.pop_word = mem[rd_ptr];
  assign cmd.level    = level_q;
  assign cmd.empty    = (level_q == '0);
  assign cmd.full     = (level_q == CMD_LEVEL_W'(CMD_DEPTH));

endmodule

/* hdl/dts_port_seq.sv */
`timescale 1ns/1ps

module dts_port_seq import dts_pkg::*; (
  input  logic             user_clk,
  input  logic             wb_rst_i,
  // Deformatter control bus
  input  logic [7:0]       data_in_i,
  input  logic [N_DTS-1:0] locked_i,
  output logic [7:0]       data_out_o,
  output logic [7:0]       addr_out_o,
  output logic [N_DTS-1:0] cs_out_o,
  output logic             wrst_o,
  output logic             rdst_o,
  output logic             unmute_o,
  // Read result back to the slave
  output logic             status_we_o,
  output logic [31:0]      status_word_o,
  // Command queue
  dts_fifo_if.reader       cmd
);

  logic [1:0]              state;
  logic [STROBE_CNT_W-1:0] strb_cnt;
  // Strobe kind of the command in flight, write wins over read
  logic                    wr_q;
  logic                    rd_q;

  // Take the next command as soon as the bus is free
  assign cmd.pop = (state == ST_IDLE) & ~cmd.empty;

  //////////////////////////////////////////////////////////////////////
  // Sequencer FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge user_clk) begin
    if (wb_rst_i) begin
      state         <= ST_IDLE;
      strb_cnt      <= '0;
      wr_q          <= 1'b0;
      rd_q          <= 1'b0;
      data_out_o    <= 8'd0;
      addr_out_o    <= 8'd0;
      cs_out_o      <= '0;
      wrst_o        <= 1'b0;
      rdst_o        <= 1'b0;
      unmute_o      <= 1'b0;
      status_we_o   <= 1'b0;
      status_word_o <= 32'd0;
    end else begin
      status_we_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Bus levels settle one cycle ahead of the strobe
          if (cmd.pop) begin
            data_out_o <= cmd.pop_word.fields.data;
            addr_out_o <= cmd.pop_word.fields.addr;
            cs_out_o   <= cmd.pop_word.fields.cs;
            unmute_o   <= cmd.pop_word.fields.unmute;
            wr_q       <= cmd.pop_word.fields.wr;
            rd_q       <= cmd.pop_word.fields.rd & ~cmd.pop_word.fields.wr;
            strb_cnt   <= '0;
            state      <= ST_STROBE;
          end
        end
        ST_STROBE: begin
          // Neither kind set, strobes stay low
          wrst_o   <= wr_q;
          rdst_o   <= rd_q;
          strb_cnt <= strb_cnt + 1'b1;
          if (strb_cnt == STROBE_CNT_W'(STROBE_CYCLES - 1)) begin
            state <= ST_GAP;
          end
        end
        ST_GAP: begin
          wrst_o <= 1'b0;
          rdst_o <= 1'b0;
          // Last read strobe cycle, capture the chip's byte
          if (rdst_o) begin
            status_word_o <= {12'd0, locked_i, data_in_i};
            status_we_o   <= 1'b1;
          end
          state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* hdl/dts_attach_top.sv */
`timescale 1ns/1ps

module dts_attach_top import dts_pkg::*; (
  input  logic             user_clk,
  input  logic             wb_rst_i,
  // Wishbone slave
  input  logic [31:0]      wb_adr_i,
  input  logic [3:0]       wb_sel_i,
  input  logic [31:0]      wb_dat_i,
  input  logic             wb_we_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  output logic [31:0]      wb_dat_o,
  output logic             wb_ack_o,
  output logic             wb_err_o,
  // Deformatter control bus
  input  logic [7:0]       data_in_i,
  input  logic [N_DTS-1:0] locked_i,
  output logic [7:0]       data_out_o,
  output logic [7:0]       addr_out_o,
  output logic [N_DTS-1:0] cs_out_o,
  output logic             wrst_o,
  output logic             rdst_o,
  output logic             unmute_o,
  // Delay control
  output logic [N_DTS-1:0] shift_advance_o,
  output logic [N_DTS-1:0] shift_delay_o,
  output logic             shift_rst_o,
  // Mux control
  output logic [47:0]      mux_control_o,
  output logic             is_three_bit_o
);

  // Sequencer read result to the slave
  logic        status_we;
  logic [31:0] status_word;

  //////////////////////////////////////////////////////////////////////
  // Command path, slave -> buffer -> sequencer
  //////////////////////////////////////////////////////////////////////

  dts_fifo_if cmd_if ();

  dts_reg_slave u_reg_slave (
    .user_clk        (user_clk),
    .wb_rst_i        (wb_rst_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_i        (wb_dat_i),
    .wb_we_i         (wb_we_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .status_we_i     (status_we),
    .status_word_i   (status_word),
    .shift_advance_o (shift_advance_o),
    .shift_delay_o   (shift_delay_o),
    .shift_rst_o     (shift_rst_o),
    .mux_control_o   (mux_control_o),
    .is_three_bit_o  (is_three_bit_o),
    .cmd             (cmd_if.writer)
  );

  // Four-deep queue of control words
  dts_cmd_fifo u_cmd_fifo (
    .user_clk (user_clk),
    .wb_rst_i (wb_rst_i),
    .cmd      (cmd_if.store)
  );

  dts_port_seq u_port_seq (
    .user_clk      (user_clk),
    .wb_rst_i      (wb_rst_i),
    .data_in_i     (data_in_i),
    .locked_i      (locked_i),
    .data_out_o    (data_out_o),
    .addr_out_o    (addr_out_o),
    .cs_out_o      (cs_out_o),
    .wrst_o        (wrst_o),
    .rdst_o        (rdst_o),
    .unmute_o      (unmute_o),
    .status_we_o   (status_we),
    .status_word_o (status_word),
    .cmd           (cmd_if.reader)
  );

endmodule

/* sim/dts_attach_props.sv */
`timescale 1ns/1ps

module dts_attach_props import dts_pkg::*; (
  input logic             user_clk,
  input logic             wb_rst_i,
  input logic             wb_ack_o,
  input logic             wb_err_o,
  input logic             wrst_o,
  input logic             rdst_o,
  input logic [N_DTS-1:0] cs_out_o
);

  // Running count of failed assertions
  int unsigned assert_fails = 0;

  // One response per transfer
  a_ack_err_excl: assert property (@(posedge user_clk) disable iff (wb_rst_i)
    !(wb_ack_o && wb_err_o))
  else begin
    assert_fails++;
    $error("wb_ack_o and wb_err_o high together");
  end

  // Ack is a single-cycle pulse
  a_ack_single: assert property (@(posedge user_clk) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
  else begin
    assert_fails++;
    $error("wb_ack_o high on two consecutive cycles");
  end

  // Deformatter bus strobes
  a_strobe_excl: assert property (@(posedge user_clk) disable iff (wb_rst_i)
    !(wrst_o && rdst_o))
  else begin
    assert_fails++;
    $error("wrst_o and rdst_o high together");
  end

  a_cs_stable: assert property (@(posedge user_clk) disable iff (wb_rst_i)
    (wrst_o || rdst_o) |-> $stable(cs_out_o))
  else begin
    assert_fails++;
    $error("cs_out_o changed during a strobe");
  end

endmodule

bind dts_attach_top dts_attach_props u_props (
  .user_clk (user_clk),
  .wb_rst_i (wb_rst_i),
  .wb_ack_o (wb_ack_o),
  .wb_err_o (wb_err_o),
  .wrst_o   (wrst_o),
  .rdst_o   (rdst_o),
  .cs_out_o (cs_out_o)
);

/* sim/tb_dts_attach.sv */
`timescale 1ns/1ps

module tb_dts_attach import dts_pkg::*; ();

  localparam int N_REG_OPS = 40;
  localparam int N_WR_CMDS = 24;
  localparam int N_RD_CMDS = 12;
  localparam int N_PRESS   = 20;
  // Rough count of bus operations in the run
  localparam int N_OPS     = 2 * N_REG_OPS + 2 * N_WR_CMDS + 4 * N_RD_CMDS + N_PRESS + 30;
  localparam int WDOG_CYC  = N_OPS * 20 + 2000;

  logic             user_clk;
  logic             wb_rst_i;
  logic [31:0]      wb_adr_i;
  logic [3:0]       wb_sel_i;
  logic [31:0]      wb_dat_i;
  logic             wb_we_i;
  logic             wb_cyc_i;
  logic             wb_stb_i;
  logic [31:0]      wb_dat_o;
  logic             wb_ack_o;
  logic             wb_err_o;
  logic [7:0]       data_in_i;
  logic [N_DTS-1:0] locked_i;
  logic [7:0]       data_out_o;
  logic [7:0]       addr_out_o;
  logic [N_DTS-1:0] cs_out_o;
  logic             wrst_o;
  logic             rdst_o;
  logic             unmute_o;
  logic [N_DTS-1:0] shift_advance_o;
  logic [N_DTS-1:0] shift_delay_o;
  logic             shift_rst_o;
  logic [47:0]      mux_control_o;
  logic             is_three_bit_o;

  // Deformatter store as seen on the bus pins
  logic [7:0]  dts_mem [N_DTS][256];
  // Same store as predicted from issued commands
  logic [7:0]  exp_mem [N_DTS][256];
  // Accepted commands not yet played out
  logic [31:0] cmd_q [$];
  // Register model
  logic [31:0] m_delay;
  logic [31:0] m_mux_lo;
  logic [15:0] m_mux_hi;
  logic        m_mode;
  logic        prev_wrst;
  logic        prev_rdst;
  int          fail_cnt;

  dts_attach_top dut (
    .user_clk        (user_clk),
    .wb_rst_i        (wb_rst_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_i        (wb_dat_i),
    .wb_we_i         (wb_we_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .data_in_i       (data_in_i),
    .locked_i        (locked_i),
    .data_out_o      (data_out_o),
    .addr_out_o      (addr_out_o),
    .cs_out_o        (cs_out_o),
    .wrst_o          (wrst_o),
    .rdst_o          (rdst_o),
    .unmute_o        (unmute_o),
    .shift_advance_o (shift_advance_o),
    .shift_delay_o   (shift_delay_o),
    .shift_rst_o     (shift_rst_o),
    .mux_control_o   (mux_control_o),
    .is_three_bit_o  (is_three_bit_o)
  );

  initial begin
    user_clk = 1'b0;
    forever #4 user_clk = ~user_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Checks and helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_cnt++;
      $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic fail_now(input string what);
    fail_cnt++;
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // Power-up contents spread over chip and byte address
  function automatic logic [7:0] fill_byte(input int chip, input int addr);
    return 8'((addr * 13) ^ (chip * 71) ^ (addr >> 3) ^ (chip << 5));
  endfunction

  function automatic int lowest_chip(input logic [N_DTS-1:0] cs);
    int idx;
    idx = 0;
    for (int i = N_DTS - 1; i >= 0; i--) begin
      if (cs[i]) idx = i;
    end
    return idx;
  endfunction

  // Fields from the top are spare, cs, unmute, rd, wr, addr and data
  function automatic logic [31:0] make_cmd(input logic wr, input logic rd);
    logic [N_DTS-1:0] cs;
    cs = N_DTS'($urandom);
    if (cs == '0) cs[$urandom % N_DTS] = 1'b1;
    return {1'b0, cs, 1'($urandom), rd, wr, 8'($urandom), 8'($urandom)};
  endfunction

  function automatic logic [31:0] reg_expect(input logic [3:0] idx);
    case (idx)
      REG_DELAY:  return m_delay;
      REG_MUX_LO: return m_mux_lo;
      REG_MUX_HI: return {16'd0, m_mux_hi};
      REG_MODE:   return {31'd0, m_mode};
      default:    return 32'd0;
    endcase
  endfunction

  // Starts on a falling edge and returns on the one after the response
  task automatic bus_write(input logic [3:0] idx, input logic [31:0] data, output logic err);
    wb_adr_i = {26'd0, idx, 2'b00};
    wb_dat_i = data;
    wb_we_i  = 1'b1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do @(negedge user_clk); while (!(wb_ack_o || wb_err_o));
    err      = wb_err_o;
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  task automatic bus_read(input logic [3:0] idx, output logic [31:0] data);
    wb_adr_i = {26'd0, idx, 2'b00};
    wb_we_i  = 1'b0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    do @(negedge user_clk); while (!(wb_ack_o || wb_err_o));
    data     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    if (wb_err_o) fail_now("register read answered with a bus error");
  endtask

  task automatic apply_reset();
    wb_rst_i = 1'b1;
    repeat (2) @(negedge user_clk);
    wb_rst_i = 1'b0;
    m_delay  = '0;
    m_mux_lo = '0;
    m_mux_hi = '0;
    m_mode   = 1'b0;
    cmd_q.delete();
  endtask

  // Accepted write commands also update the expected store
  task automatic send_cmd(input logic [31:0] w, output logic err);
    bus_write(REG_CONTROL, w, err);
    if (!err) begin
      cmd_q.push_back(w);
      for (int c = 0; c < N_DTS; c++) begin
        if (w[16] && w[19 + c]) exp_mem[c][w[15:8]] = w[7:0];
      end
    end
  endtask

  // Wait for an empty buffer and then for the last command to finish
  task automatic wait_drained();
    logic [31:0] st;
    do bus_read(REG_STATUS, st); while (!st[8]);
    repeat (8) @(negedge user_clk);
  endtask

  task automatic check_regs();
    logic [31:0] rd;
    for (int i = 1; i <= 4; i++) begin
      bus_read(4'(i), rd);
      check($sformatf("wb_dat_o reg %0d", i), rd, reg_expect(4'(i)));
    end
    check("shift_advance_o", shift_advance_o, m_delay[11:0]);
    check("shift_delay_o", shift_delay_o, m_delay[23:12]);
    check("shift_rst_o", shift_rst_o, m_delay[31]);
    check("mux_control_o", mux_control_o, {m_mux_hi, m_mux_lo});
    check("is_three_bit_o", is_three_bit_o, m_mode);
  endtask

  task automatic compare_mems();
    for (int c = 0; c < N_DTS; c++) begin
      for (int a = 0; a < 256; a++) begin
        check($sformatf("dts_mem[%0d][%0h]", c, a), dts_mem[c][a], exp_mem[c][a]);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Deformatter model
  //////////////////////////////////////////////////////////////////////

  always @(negedge user_clk) begin
    logic [31:0] w;
    // Lowest selected chip answers a read
    data_in_i = rdst_o ? dts_mem[lowest_chip(cs_out_o)][addr_out_o] : 8'h00;
    // End of a strobe retires the oldest command
    if ((prev_wrst && !wrst_o) || (prev_rdst && !rdst_o)) begin
      if (cmd_q.size() == 0) begin
        fail_now("strobe seen with no command outstanding");
      end else begin
        w = cmd_q.pop_front();
        check("strobe kind", {prev_wrst, prev_rdst}, {w[16], w[17]});
        check("addr_out_o", addr_out_o, w[15:8]);
        check("cs_out_o", cs_out_o, w[30:19]);
        check("unmute_o", unmute_o, w[18]);
        if (prev_wrst) begin
          check("data_out_o", data_out_o, w[7:0]);
          for (int c = 0; c < N_DTS; c++) begin
            if (cs_out_o[c]) dts_mem[c][addr_out_o] = data_out_o;
          end
        end
      end
    end
    prev_wrst = wrst_o;
    prev_rdst = rdst_o;
  end

  // Bound assertions
  always @(negedge user_clk) begin
    if (dut.u_props.assert_fails != 0) fail_now("a protocol assertion failed");
  end

  initial begin
    repeat (WDOG_CYC) @(posedge user_clk);
    $display("watchdog fired, run timed out after %0d cycles", WDOG_CYC);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] st;
    logic [31:0] w;
    logic [31:0] w_wr;
    logic [3:0]  idx;
    logic        err;
    logic        saw_err;
    void'($urandom(69));
    fail_cnt  = 0;
    wb_rst_i  = 1'b1;
    wb_adr_i  = '0;
    wb_sel_i  = 4'hf;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    data_in_i = 8'h00;
    locked_i  = '0;
    prev_wrst = 1'b0;
    prev_rdst = 1'b0;
    for (int c = 0; c < N_DTS; c++) begin
      for (int a = 0; a < 256; a++) begin
        dts_mem[c][a] = fill_byte(c, a);
        exp_mem[c][a] = fill_byte(c, a);
      end
    end
    apply_reset();

    // Reset state
    check("wrst_o", wrst_o, 1'b0);
    check("rdst_o", rdst_o, 1'b0);
    check("unmute_o", unmute_o, 1'b0);
    check("cs_out_o", cs_out_o, '0);
    bus_read(REG_STATUS, st);
    check("status after reset", st, 32'h0000_0100);
    bus_read(REG_CONTROL, rd);
    check("control after reset", rd, 32'd0);
    bus_read(4'd6, rd);
    check("unused register", rd, 32'd0);
    check_regs();

    // Register read-back
    repeat (N_REG_OPS) begin
      idx = 4'(1 + $urandom % 4);
      w   = $urandom;
      bus_write(idx, w, err);
      check("wb_err_o", err, 1'b0);
      case (idx)
        REG_DELAY:  m_delay  = w;
        REG_MUX_LO: m_mux_lo = w;
        REG_MUX_HI: m_mux_hi = w[15:0];
        default:    m_mode   = w[0];
      endcase
      idx = 4'(1 + $urandom % 4);
      bus_read(idx, rd);
      check("wb_dat_o", rd, reg_expect(idx));
    end
    check_regs();

    // Deformatter writes one at a time
    repeat (N_WR_CMDS) begin
      send_cmd(make_cmd(1'b1, 1'b0), err);
      check("wb_err_o", err, 1'b0);
      do bus_read(REG_STATUS, st); while (!st[8]);
    end
    wait_drained();
    compare_mems();

    // Write then read the same byte queued back to back
    repeat (N_RD_CMDS) begin
      locked_i = N_DTS'($urandom);
      w        = make_cmd(1'b0, 1'b1);
      w_wr     = make_cmd(1'b1, 1'b0);
      w_wr[15:8] = w[15:8];
      send_cmd(w_wr, err);
      check("wb_err_o", err, 1'b0);
      send_cmd(w, err);
      check("wb_err_o", err, 1'b0);
      wait_drained();
      bus_read(REG_CONTROL, rd);
      check("status word", rd, {12'd0, locked_i, exp_mem[lowest_chip(w[30:19])][w[15:8]]});
      check("unmute_o", unmute_o, w[18]);
    end

    // Back-pressure from a fresh reset
    apply_reset();
    repeat (4) begin
      send_cmd(make_cmd(1'b1, 1'b0), err);
      check("wb_err_o", err, 1'b0);
    end
    saw_err = 1'b0;
    for (int i = 0; i < N_PRESS && !saw_err; i++) begin
      bus_read(REG_STATUS, st);
      send_cmd(make_cmd(1'b1, 1'b0), err);
      // Refusal only possible when the buffer was already full
      if (err) begin
        saw_err = 1'b1;
        check("full before refused write", st[9], 1'b1);
      end
    end
    if (!saw_err) fail_now("full command buffer never refused a control write");
    wait_drained();
    compare_mems();
    check("commands left unplayed", cmd_q.size(), 0);
    check_regs();

    if (fail_cnt == 0 && dut.u_props.assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
hdl/dts_pkg.sv
hdl/dts_fifo_if.sv
hdl/dts_reg_slave.sv
hdl/dts_cmd_fifo.sv
hdl/dts_port_seq.sv
hdl/dts_attach_top.sv
sim/dts_attach_props.sv
sim/tb_dts_attach.sv
